/* test/golden_core.txt */
# I <instruction word>, one per line in program order
# E <pc> <rd> <data> <illegal>, one per line in retirement order
I 00500093
I FFD00113
I 002081B3
I 40208233
I 401152B3
I 00115333
I 001093B3
I 00112433
I 001134B3
I 0020C533
I 0020E5B3
I 0020F633
I 123456B7
I 67868693
I 00001717
I 00469793
I 40115813
I 01C15893
I FFE12913
I FFF0B993
I FFF0CA13
I 0F00EA93
I 0FF6FB13
I 00708013
I 00100BB3
I 00002083
I 00008C33
I 417C0CB3
I FFFFFD17
I 404D5D93
I 001D5E33
E 00000000 01 00000005 0
E 00000004 02 FFFFFFFD 0
E 00000008 03 00000002 0
E 0000000C 04 00000008 0
E 00000010 05 FFFFFFFF 0
E 00000014 06 07FFFFFF 0
E 00000018 07 000000A0 0
E 0000001C 08 00000001 0
E 00000020 09 00000000 0
E 00000024 0A FFFFFFF8 0
E 00000028 0B FFFFFFFD 0
E 0000002C 0C 00000005 0
E 00000030 0D 12345000 0
E 00000034 0D 12345678 0
E 00000038 0E 00001038 0
E 0000003C 0F 23456780 0
E 00000040 10 FFFFFFFE 0
E 00000044 11 0000000F 0
E 00000048 12 00000001 0
E 0000004C 13 00000001 0
E 00000050 14 FFFFFFFA 0
E 00000054 15 000000F5 0
E 00000058 16 00000078 0
E 0000005C 00 0000000C 0
E 00000060 17 00000005 0
E 00000064 01 00000000 1
E 00000068 18 00000005 0
E 0000006C 19 00000000 0
E 00000070 1A FFFFF070 0
E 00000074 1B FFFFFF07 0
E 00000078 1C 07FFFF83 0

/* build.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/de_pipe_reg.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
test/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_core -Mdir obj_dir -o tb_core_sim &&
./obj_dir/tb_core_sim | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* test/tb_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;

    localparam time CLK_PERIOD   = 100ns;
    localparam int  RESET_CYCLES = 16;
    localparam int  DRAIN_CYCLES = 20;

    logic             clk;
    logic             rst_n_i;
    logic             instr_valid_i;
    logic [`XLEN-1:0] instr_i;
    logic             instr_credit_o;
    logic             result_credit_i;
    logic             result_valid_o;
    logic [`XLEN-1:0] result_pc_o;
    logic [4:0]       result_rd_o;
    logic [`XLEN-1:0] result_data_o;
    logic             result_illegal_o;

    logic [31:0] program_q [$];
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_ill_q [$];

    int num_instr;
    int num_expect;
    int sent;
    int retired;
    int mismatch_errs;
    int other_errs;
    bit loaded;

    core_top dut_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .instr_credit_o(instr_credit_o),
        .result_credit_i(result_credit_i), .result_valid_o(result_valid_o),
        .result_pc_o(result_pc_o), .result_rd_o(result_rd_o),
        .result_data_o(result_data_o), .result_illegal_o(result_illegal_o)
    );

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        fd = $fopen("test/golden_core.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file test/golden_core.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "I %h", a) == 1) begin
                program_q.push_back(a);
            end else if (n > 0 && $sscanf(line, "E %h %h %h %h", a, b, c, d) == 4) begin
                exp_pc_q.push_back(a);
                exp_rd_q.push_back(b);
                exp_data_q.push_back(c);
                exp_ill_q.push_back(d[0]);
            end
        end
        $fclose(fd);
        num_instr  = program_q.size();
        num_expect = exp_pc_q.size();
    endtask

    task automatic compare(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
            mismatch_errs++;
        end
    endtask

    task automatic check_beat();
        string tag;
        if (retired >= num_expect) begin
            $display("Result beat at pc %h came after all %0d expected results",
                     result_pc_o, num_expect);
            other_errs++;
            return;
        end
        tag = $sformatf("instr %0d (%h)", retired, program_q[retired]);
        compare({tag, " pc"}, exp_pc_q[retired], result_pc_o);
        compare({tag, " illegal"}, 32'(exp_ill_q[retired]), 32'(result_illegal_o));
        // rd and data of an illegal word carry no meaning
        if (!exp_ill_q[retired]) begin
            compare({tag, " rd"}, exp_rd_q[retired], 32'(result_rd_o));
            compare({tag, " data"}, exp_data_q[retired], result_data_o);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Sampled mid-cycle, where the registered outputs are settled
    always @(negedge clk) begin
        if (rst_n_i && result_valid_o) begin
            check_beat();
            retired++;
        end
    end

    initial begin : sender
        int credits;
        int cyc;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        credits       = `IN_CREDITS;
        cyc           = 0;
        wait (loaded && rst_n_i);
        while (sent < num_instr) begin
            @(posedge clk);
            #1;
            cyc++;
            if (instr_credit_o) begin
                credits++;
            end
            if (credits > `IN_CREDITS) begin
                $display("Input credits returned beyond the queue depth, now %0d", credits);
                other_errs++;
            end
            // Idle now and then so decode sees bubbles
            if (credits > 0 && (cyc % 9) != 4) begin
                instr_valid_i = 1'b1;
                instr_i       = program_q[sent];
                credits--;
                sent++;
            end else begin
                instr_valid_i = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
    end

    initial begin : consumer
        int returned;
        int delay;
        int seed_val;
        result_credit_i = 1'b0;
        returned        = 0;
        seed_val        = $urandom(32'h9ba4);
        forever begin
            @(posedge clk);
            #1;
            result_credit_i = 1'b0;
            if (returned < retired) begin
                delay = $urandom % 6;
                if (delay > 0) begin
                    repeat (delay) @(posedge clk);
                    #1;
                end
                result_credit_i = 1'b1;
                returned++;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (20 * num_instr + RESET_CYCLES) @(posedge clk);
        $display("Timeout with %0d of %0d results retired and %0d of %0d words sent",
                 retired, num_expect, sent, num_instr);
        other_errs++;
        finish_run();
    end

    initial begin : main
        rst_n_i = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        if (instr_credit_o || result_valid_o) begin
            $display("Credit or result output was high right after reset");
            other_errs++;
        end
        wait (retired >= num_expect);
        // Extra beats would show up here
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (num_instr != num_expect) begin
            $display("Golden file holds %0d words but %0d expected results",
                     num_instr, num_expect);
            other_errs++;
        end
        if (retired != num_expect) begin
            $display("Retired %0d results where %0d were expected", retired, num_expect);
            other_errs++;
        end
        finish_run();
    end

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             instr_valid_i,
    input  logic [`XLEN-1:0] instr_i,
    output logic             instr_credit_o,
    input  logic             result_credit_i,
    output logic             result_valid_o,
    output logic [`XLEN-1:0] result_pc_o,
    output logic [4:0]       result_rd_o,
    output logic [`XLEN-1:0] result_data_o,
    output logic             result_illegal_o
);
    import pipe_pkg::*;

    logic             stall;
    logic [4:0]       rf_rs1_addr;
    logic [4:0]       rf_rs2_addr;
    logic [`XLEN-1:0] rf_rs1_data;
    logic [`XLEN-1:0] rf_rs2_data;

    logic             d_valid;
    logic             d_reg_write;
    alu_op_e          d_alu_op;
    src_a_e           d_src_a;
    logic             d_src_b_imm;
    logic [`XLEN-1:0] d_rs1_val;
    logic [`XLEN-1:0] d_rs2_val;
    logic [`XLEN-1:0] d_pc;
    logic [`XLEN-1:0] d_imm;
    logic [4:0]       d_rd;
    logic [4:0]       d_rs1;
    logic [4:0]       d_rs2;
    logic             d_illegal;
    logic             d_bubble;

    logic             e_valid;
    logic             e_reg_write;
    alu_op_e          e_alu_op;
    src_a_e           e_src_a;
    logic             e_src_b_imm;
    logic [`XLEN-1:0] e_rs1_val;
    logic [`XLEN-1:0] e_rs2_val;
    logic [`XLEN-1:0] e_pc;
    logic [`XLEN-1:0] e_imm;
    logic [4:0]       e_rd;
    logic [4:0]       e_rs1;
    logic [4:0]       e_rs2;
    logic             e_illegal;

    logic             ex_valid;
    logic             ex_reg_write;
    logic [4:0]       ex_rd;
    logic [`XLEN-1:0] ex_data;
    logic [`XLEN-1:0] ex_pc;
    logic             ex_illegal;

    logic             wb_en;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;

    reg_file reg_file_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .rs1_addr_i(rf_rs1_addr), .rs2_addr_i(rf_rs2_addr),
        .rs1_data_o(rf_rs1_data), .rs2_data_o(rf_rs2_data),
        .wr_en_i(wb_en), .wr_addr_i(wb_rd), .wr_data_i(wb_data)
    );

    decode_stage decode_stage_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .instr_credit_o(instr_credit_o),
        .stall_i(stall),
        .rs1_addr_o(rf_rs1_addr), .rs2_addr_o(rf_rs2_addr),
        .rs1_data_i(rf_rs1_data), .rs2_data_i(rf_rs2_data),
        .valid_o(d_valid), .reg_write_o(d_reg_write), .alu_op_o(d_alu_op),
        .src_a_o(d_src_a), .src_b_imm_o(d_src_b_imm),
        .rs1_val_o(d_rs1_val), .rs2_val_o(d_rs2_val), .pc_o(d_pc), .imm_o(d_imm),
        .rd_o(d_rd), .rs1_o(d_rs1), .rs2_o(d_rs2),
        .illegal_o(d_illegal), .bubble_o(d_bubble)
    );

    de_pipe_reg de_pipe_reg_i (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .bubble_i(d_bubble),
        .valid_d_i(d_valid), .reg_write_d_i(d_reg_write), .alu_op_d_i(d_alu_op),
        .src_a_d_i(d_src_a), .src_b_imm_d_i(d_src_b_imm),
        .rs1_val_d_i(d_rs1_val), .rs2_val_d_i(d_rs2_val), .pc_d_i(d_pc), .imm_d_i(d_imm),
        .rd_d_i(d_rd), .rs1_d_i(d_rs1), .rs2_d_i(d_rs2), .illegal_d_i(d_illegal),
        .valid_e_o(e_valid), .reg_write_e_o(e_reg_write), .alu_op_e_o(e_alu_op),
        .src_a_e_o(e_src_a), .src_b_imm_e_o(e_src_b_imm),
        .rs1_val_e_o(e_rs1_val), .rs2_val_e_o(e_rs2_val), .pc_e_o(e_pc), .imm_e_o(e_imm),
        .rd_e_o(e_rd), .rs1_e_o(e_rs1), .rs2_e_o(e_rs2), .illegal_e_o(e_illegal)
    );

    execute_stage execute_stage_i (
        .valid_i(e_valid), .reg_write_i(e_reg_write), .alu_op_i(e_alu_op),
        .src_a_i(e_src_a), .src_b_imm_i(e_src_b_imm),
        .rs1_val_i(e_rs1_val), .rs2_val_i(e_rs2_val), .pc_i(e_pc), .imm_i(e_imm),
        .rd_i(e_rd), .rs1_i(e_rs1), .rs2_i(e_rs2), .illegal_i(e_illegal),
        .fwd_wr_en_i(wb_en), .fwd_rd_i(wb_rd), .fwd_data_i(wb_data),
        .ex_valid_o(ex_valid), .ex_reg_write_o(ex_reg_write), .ex_rd_o(ex_rd),
        .ex_data_o(ex_data), .ex_pc_o(ex_pc), .ex_illegal_o(ex_illegal)
    );

    result_stage result_stage_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .ex_valid_i(ex_valid), .ex_reg_write_i(ex_reg_write), .ex_rd_i(ex_rd),
        .ex_data_i(ex_data), .ex_pc_i(ex_pc), .ex_illegal_i(ex_illegal),
        .result_credit_i(result_credit_i), .stall_o(stall),
        .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .result_valid_o(result_valid_o), .result_pc_o(result_pc_o),
        .result_rd_o(result_rd_o), .result_data_o(result_data_o),
        .result_illegal_o(result_illegal_o)
    );

endmodule

/* hw/result_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module result_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             ex_valid_i,
    input  logic             ex_reg_write_i,
    input  logic [4:0]       ex_rd_i,
    input  logic [`XLEN-1:0] ex_data_i,
    input  logic [`XLEN-1:0] ex_pc_i,
    input  logic             ex_illegal_i,
    input  logic             result_credit_i,
    output logic             stall_o,
    output logic             wb_en_o,
    output logic [4:0]       wb_rd_o,
    output logic [`XLEN-1:0] wb_data_o,
    output logic             result_valid_o,
    output logic [`XLEN-1:0] result_pc_o,
    output logic [4:0]       result_rd_o,
    output logic [`XLEN-1:0] result_data_o,
    output logic             result_illegal_o
);
    localparam int CW = $clog2(`OUT_CREDITS + 1);

    logic             w_valid;
    logic             w_reg_write;
    logic [4:0]       w_rd;
    logic [`XLEN-1:0] w_data;
    logic [`XLEN-1:0] w_pc;
    logic             w_illegal;
    logic [CW-1:0]    credit_cnt;
    logic             fire;

    assign fire    = w_valid && (credit_cnt != '0);
    assign stall_o = w_valid && (credit_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            w_valid     <= 1'b0;
            w_reg_write <= 1'b0;
        end else if (!stall_o) begin
            w_valid     <= ex_valid_i;
            w_reg_write <= ex_reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            w_rd      <= ex_rd_i;
            w_data    <= ex_data_i;
            w_pc      <= ex_pc_i;
            w_illegal <= ex_illegal_i;
        end
    end

    // Saturates at the initial count
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_cnt <= CW'(`OUT_CREDITS);
        end else if (fire && !result_credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!fire && result_credit_i && credit_cnt != CW'(`OUT_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    assign result_valid_o   = fire;
    assign result_pc_o      = w_pc;
    assign result_rd_o      = w_rd;
    assign result_data_o    = w_data;
    assign result_illegal_o = w_illegal;
    assign wb_en_o          = fire && w_reg_write;
    assign wb_rd_o          = w_rd;
    assign wb_data_o        = w_data;

    // Credits come back only for beats already sent
    assert property (@(posedge clk) disable iff (!rst_n_i)
        result_credit_i && !fire |-> credit_cnt != CW'(`OUT_CREDITS));

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic              valid_i,
    input  logic              reg_write_i,
    input  pipe_pkg::alu_op_e alu_op_i,
    input  pipe_pkg::src_a_e  src_a_i,
    input  logic              src_b_imm_i,
    input  logic [`XLEN-1:0]  rs1_val_i,
    input  logic [`XLEN-1:0]  rs2_val_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  logic [`XLEN-1:0]  imm_i,
    input  logic [4:0]        rd_i,
    input  logic [4:0]        rs1_i,
    input  logic [4:0]        rs2_i,
    input  logic              illegal_i,
    input  logic              fwd_wr_en_i,
    input  logic [4:0]        fwd_rd_i,
    input  logic [`XLEN-1:0]  fwd_data_i,
    output logic              ex_valid_o,
    output logic              ex_reg_write_o,
    output logic [4:0]        ex_rd_o,
    output logic [`XLEN-1:0]  ex_data_o,
    output logic [`XLEN-1:0]  ex_pc_o,
    output logic              ex_illegal_o
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] rs1_fwd;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;

    // Previous instruction sits in W and is written this cycle
    assign rs1_fwd = (fwd_wr_en_i && fwd_rd_i != 5'd0 && fwd_rd_i == rs1_i) ? fwd_data_i
                                                                          : rs1_val_i;
    assign rs2_fwd = (fwd_wr_en_i && fwd_rd_i != 5'd0 && fwd_rd_i == rs2_i) ? fwd_data_i
                                                                          : rs2_val_i;

    always_comb begin
        case (src_a_i)
            SRC_A_RS1:  op_a = rs1_fwd;
            SRC_A_PC:   op_a = pc_i;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = '0;
        endcase
    end

    assign op_b  = src_b_imm_i ? imm_i : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  ex_data_o = op_a + op_b;
            ALU_SUB:  ex_data_o = op_a - op_b;
            ALU_SLL:  ex_data_o = op_a << shamt;
            ALU_SLT:  ex_data_o = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: ex_data_o = `XLEN'(op_a < op_b);
            ALU_XOR:  ex_data_o = op_a ^ op_b;
            ALU_SRL:  ex_data_o = op_a >> shamt;
            ALU_SRA:  ex_data_o = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   ex_data_o = op_a | op_b;
            ALU_AND:  ex_data_o = op_a & op_b;
            default:  ex_data_o = '0;
        endcase
    end

    assign ex_valid_o     = valid_i;
    assign ex_reg_write_o = valid_i && reg_write_i;
    assign ex_rd_o        = rd_i;
    assign ex_pc_o        = pc_i;
    assign ex_illegal_o   = illegal_i;

endmodule

/* hw/de_pipe_reg.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module de_pipe_reg (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              bubble_i,
    input  logic              valid_d_i,
    input  logic              reg_write_d_i,
    input  pipe_pkg::alu_op_e alu_op_d_i,
    input  pipe_pkg::src_a_e  src_a_d_i,
    input  logic              src_b_imm_d_i,
    input  logic [`XLEN-1:0]  rs1_val_d_i,
    input  logic [`XLEN-1:0]  rs2_val_d_i,
    input  logic [`XLEN-1:0]  pc_d_i,
    input  logic [`XLEN-1:0]  imm_d_i,
    input  logic [4:0]        rd_d_i,
    input  logic [4:0]        rs1_d_i,
    input  logic [4:0]        rs2_d_i,
    input  logic              illegal_d_i,
    output logic              valid_e_o,
    output logic              reg_write_e_o,
    output pipe_pkg::alu_op_e alu_op_e_o,
    output pipe_pkg::src_a_e  src_a_e_o,
    output logic              src_b_imm_e_o,
    output logic [`XLEN-1:0]  rs1_val_e_o,
    output logic [`XLEN-1:0]  rs2_val_e_o,
    output logic [`XLEN-1:0]  pc_e_o,
    output logic [`XLEN-1:0]  imm_e_o,
    output logic [4:0]        rd_e_o,
    output logic [4:0]        rs1_e_o,
    output logic [4:0]        rs2_e_o,
    output logic              illegal_e_o
);
    import pipe_pkg::*;

    // Stall holds, bubble loads an all-zero entry, otherwise capture
    always_ff @(posedge clk) begin
        if (!rst_n_i || (bubble_i && !stall_i)) begin
            valid_e_o     <= 1'b0;
            reg_write_e_o <= 1'b0;
            alu_op_e_o    <= ALU_ADD;
            src_a_e_o     <= SRC_A_RS1;
            src_b_imm_e_o <= 1'b0;
            rs1_val_e_o   <= '0;
            rs2_val_e_o   <= '0;
            pc_e_o        <= '0;
            imm_e_o       <= '0;
            rd_e_o        <= '0;
            rs1_e_o       <= '0;
            rs2_e_o       <= '0;
            illegal_e_o   <= 1'b0;
        end else if (!stall_i) begin
            valid_e_o     <= valid_d_i;
            reg_write_e_o <= reg_write_d_i;
            alu_op_e_o    <= alu_op_d_i;
            src_a_e_o     <= src_a_d_i;
            src_b_imm_e_o <= src_b_imm_d_i;
            rs1_val_e_o   <= rs1_val_d_i;
            rs2_val_e_o   <= rs2_val_d_i;
            pc_e_o        <= pc_d_i;
            imm_e_o       <= imm_d_i;
            rd_e_o        <= rd_d_i;
            rs1_e_o       <= rs1_d_i;
            rs2_e_o       <= rs2_d_i;
            illegal_e_o   <= illegal_d_i;
        end
    end

    // A bubble never replaces an instruction that decode presents
    assert property (@(posedge clk) disable iff (!rst_n_i)
        bubble_i |-> !valid_d_i);

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              instr_valid_i,
    input  logic [`XLEN-1:0]  instr_i,
    output logic              instr_credit_o,
    input  logic              stall_i,
    output logic [4:0]        rs1_addr_o,
    output logic [4:0]        rs2_addr_o,
    input  logic [`XLEN-1:0]  rs1_data_i,
    input  logic [`XLEN-1:0]  rs2_data_i,
    output logic              valid_o,
    output logic              reg_write_o,
    output pipe_pkg::alu_op_e alu_op_o,
    output pipe_pkg::src_a_e  src_a_o,
    output logic              src_b_imm_o,
    output logic [`XLEN-1:0]  rs1_val_o,
    output logic [`XLEN-1:0]  rs2_val_o,
    output logic [`XLEN-1:0]  pc_o,
    output logic [`XLEN-1:0]  imm_o,
    output logic [4:0]        rd_o,
    output logic [4:0]        rs1_o,
    output logic [4:0]        rs2_o,
    output logic              illegal_o,
    output logic              bubble_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int DEPTH = `IN_CREDITS;
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    instr_u           queue_mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic [`XLEN-1:0] pc_q;
    logic             empty;
    logic             pop;
    instr_u           head;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Shared by OP and OP-IMM, which differ only in SUB
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_sel,
                                            input logic sra_sel);
        case (f3)
            F3_ADD:  return sub_sel ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return sra_sel ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign empty = (count == '0);
    assign pop   = !empty && !stall_i;
    assign head  = queue_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            queue_mem[wr_ptr] <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            pc_q           <= '0;
            instr_credit_o <= 1'b0;
        end else begin
            if (instr_valid_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
                pc_q   <= pc_q + `XLEN'(4);
            end
            count          <= count + CW'(instr_valid_i) - CW'(pop);
            // One credit back per entry leaving the queue
            instr_credit_o <= pop;
        end
    end

    // Defaults give zero data for an illegal word
    always_comb begin
        reg_write_o = 1'b0;
        alu_op_o    = ALU_ADD;
        src_a_o     = SRC_A_ZERO;
        src_b_imm_o = 1'b1;
        imm_o       = '0;
        illegal_o   = 1'b0;
        case (head.r.opcode)
            OPC_OP: begin
                reg_write_o = 1'b1;
                src_a_o     = SRC_A_RS1;
                src_b_imm_o = 1'b0;
                alu_op_o    = alu_from_f3(head.r.funct3, head.r.funct7[5], head.r.funct7[5]);
            end
            OPC_OP_IMM: begin
                reg_write_o = 1'b1;
                src_a_o     = SRC_A_RS1;
                imm_o       = {{(`XLEN - 12){head.i.imm[11]}}, head.i.imm};
                // imm bit 10 is funct7 bit 5 for SRAI
                alu_op_o    = alu_from_f3(head.i.funct3, 1'b0, head.i.imm[10]);
            end
            OPC_LUI, OPC_AUIPC: begin
                reg_write_o = 1'b1;
                src_a_o     = (head.u.opcode == OPC_AUIPC) ? SRC_A_PC : SRC_A_ZERO;
                imm_o       = {head.u.imm, 12'b0};
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

    assign valid_o    = !empty;
    assign bubble_o   = empty;
    assign rs1_addr_o = head.r.rs1;
    assign rs2_addr_o = head.r.rs2;
    assign rs1_o      = head.r.rs1;
    assign rs2_o      = head.r.rs2;
    assign rd_o       = head.r.rd;
    assign rs1_val_o  = rs1_data_i;
    assign rs2_val_o  = rs2_data_i;
    assign pc_o       = pc_q;

    // Source must hold a credit, so it never pushes into a full queue
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(instr_valid_i && count == CW'(DEPTH)));

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [$clog2(`NUM_REGS)-1:0] rs1_addr_i,
    input  logic [$clog2(`NUM_REGS)-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]             rs1_data_o,
    output logic [`XLEN-1:0]             rs2_data_o,
    input  logic                         wr_en_i,
    input  logic [$clog2(`NUM_REGS)-1:0] wr_addr_i,
    input  logic [`XLEN-1:0]             wr_data_i
);
    localparam int AW = $clog2(`NUM_REGS);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 reads zero, a same-cycle write is seen by the reader
    function automatic logic [`XLEN-1:0] read_reg(input logic [AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en_i && addr == wr_addr_i) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_reg(rs1_addr_i);
        rs2_data_o = read_reg(rs2_addr_i);
    end

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;

    // ALU operation carried from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Operand A source
    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

endpackage

/* hw/isa_pkg.sv */
package isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    // One instruction word, read through whichever format the opcode implies
    typedef union packed {
        r_view_t r;
        i_view_t i;
        u_view_t u;
    } instr_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* hw/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath width
`define XLEN 32

// Architectural registers, 5-bit index
`define NUM_REGS 32

// Input queue depth, also the source's starting credits
`define IN_CREDITS 4

// Result stream credits held after reset
`define OUT_CREDITS 2

`endif
